// File: Bender.yml
package:
  name: l2_cache

sources:
  - verilog/cache_cfg_pkg.sv
  - verilog/bus_pkg.sv
  - verilog/l2_req_decode.sv
  - verilog/l2_line_engine.sv
  - verilog/l2_resp_queue.sv
  - verilog/l2_cache_top.sv
  - target: test
    files:
      - testbench/burst_mem_model.sv
      - testbench/l2_checker.sv
      - testbench/tb_l2_cache.sv

// File: sim.f
verilog/cache_cfg_pkg.sv
verilog/bus_pkg.sv
verilog/l2_req_decode.sv
verilog/l2_line_engine.sv
verilog/l2_resp_queue.sv
verilog/l2_cache_top.sv
testbench/burst_mem_model.sv
testbench/l2_checker.sv
testbench/tb_l2_cache.sv

// File: testbench/burst_mem_model.sv
`timescale 1ns/1ps

module burst_mem_model #(
   parameter int ACK_DELAY = 2
) (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             mem_req,
   input  bus_pkg::mem_cmd_t                mem_cmd,
   output logic                             mem_ack,
   output logic [cache_cfg_pkg::WORD_W-1:0] mem_rdata,
   output logic                             mem_rvalid,
   input  logic [cache_cfg_pkg::WORD_W-1:0] mem_wdata,
   output logic                             mem_wrdy
);
   import cache_cfg_pkg::*;
   import bus_pkg::*;

   logic [WORD_W-1:0] store [int];   // Only words written back so far
   mem_cmd_t          cmd;
   int                base;

   function automatic logic [WORD_W-1:0] read_word(input int a);
      if (store.exists(a)) begin
         return store[a];
      end
      return WORD_W'(a) ^ 32'h5a5a_0000;   // Untouched word, keyed by word address
   endfunction

   initial begin
      mem_ack    = 1'b0;
      mem_rdata  = '0;
      mem_rvalid = 1'b0;
      mem_wrdy   = 1'b0;
      forever begin
         @(posedge clk);
         if (!rst && mem_req) begin
            cmd  = mem_cmd;
            base = int'({cmd.line, 2'b00});
            repeat (ACK_DELAY) @(posedge clk);
            mem_ack <= 1'b1;
            @(posedge clk);
            mem_ack <= 1'b0;
            if (cmd.write) begin
               mem_wrdy <= 1'b1;
               for (int w = 0; w < LINE_WORDS; w++) begin
                  @(posedge clk);
                  store[base + w] = mem_wdata;
               end
               mem_wrdy <= 1'b0;
            end else begin
               for (int w = 0; w < LINE_WORDS; w++) begin
                  mem_rvalid <= 1'b1;
                  mem_rdata  <= read_word(base + w);   // Lowest word first
                  @(posedge clk);
               end
               mem_rvalid <= 1'b0;
            end
         end
      end
   end

endmodule

// File: testbench/cache_input.txt
// op addr mask wdata expected, all hex; op 1 is a write, which answers with the merged word
// an untouched memory word at word address a holds a ^ 5a5a0000
0 000104 0 00000000 5a5a0104
0 000107 0 00000000 5a5a0107
1 000105 3 deadbeef 5a5abeef
0 000105 0 00000000 5a5abeef
1 000106 c 12345678 12340106
0 012304 0 00000000 5a5b2304
0 000105 0 00000000 5a5abeef
0 000106 0 00000000 12340106
1 7fff00 f cafef00d cafef00d
0 000001 0 00000000 5a5a0001
0 7fff00 0 00000000 cafef00d
1 2a5a3c 5 11223344 5a225a44
0 2a5a3c 0 00000000 5a225a44
0 2a5a3d 0 00000000 5a705a3d

// File: testbench/l2_checker.sv
`timescale 1ns/1ps

module l2_checker (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             req_valid,
   input  logic                             req_credit,
   input  logic                             rsp_valid,
   input  bus_pkg::rsp_t                    rsp,
   input  logic                             exp_valid,
   input  logic                             exp_write,
   input  logic [cache_cfg_pkg::WORD_W-1:0] exp_rdata,
   input  logic                             end_check,
   input  int                               n_req,
   output int                               data_errors,
   output int                               proto_errors,
   output int                               rsp_seen
);
   import bus_pkg::*;

   rsp_t exp_q [$];
   rsp_t want;
   int   sent;
   int   returned;
   logic checked;

   always @(posedge clk) begin
      if (rst) begin
         exp_q.delete();
         sent         = 0;
         returned     = 0;
         checked      = 1'b0;
         data_errors  = 0;
         proto_errors = 0;
         rsp_seen     = 0;
      end else begin
         if (exp_valid) begin
            want.write = exp_write;
            want.rdata = exp_rdata;
            exp_q.push_back(want);
         end
         if (req_valid) begin
            sent++;
         end
         if (req_credit) begin
            returned++;
         end
         if (returned > sent) begin
            $display("Cache returned %0d request credits for only %0d requests sent",
                     returned, sent);
            proto_errors++;
         end
         if (rsp_valid) begin
            if (exp_q.size() == 0) begin
               $display("Response arrived with no request waiting for it");
               proto_errors++;
            end else begin
               want = exp_q.pop_front();   // Responses come back in request order
               if (rsp !== want) begin
                  $display("ERROR %0t: response %0d write=%0b data %h, expected write=%0b data %h",
                           $time, rsp_seen, rsp.write, rsp.rdata, want.write, want.rdata);
                  data_errors++;
               end
            end
            rsp_seen++;
         end
         if (end_check && !checked) begin
            checked = 1'b1;
            if (rsp_seen != n_req) begin
               $display("Missing responses: got %0d of %0d", rsp_seen, n_req);
               proto_errors++;
            end
            if (returned != n_req) begin
               $display("Cache returned %0d request credits for %0d requests", returned, n_req);
               proto_errors++;
            end
         end
      end
   end

endmodule

// File: testbench/tb_l2_cache.sv
`timescale 1ns/1ps

module tb_l2_cache;
   import cache_cfg_pkg::*;
   import bus_pkg::*;

   localparam int          REQ_CREDITS = 4;
   localparam int          RSP_DEPTH   = 4;
   localparam logic [31:0] SEED        = 32'h80fd_f6f7;

   logic              clk;
   logic              rst;
   logic              req_valid;
   req_t              req;
   logic              req_credit;
   logic              rsp_valid;
   rsp_t              rsp;
   logic              rsp_credit;
   logic              mem_req;
   mem_cmd_t          mem_cmd;
   logic              mem_ack;
   logic [WORD_W-1:0] mem_rdata;
   logic              mem_rvalid;
   logic [WORD_W-1:0] mem_wdata;
   logic              mem_wrdy;

   logic              exp_valid;
   logic              exp_write;
   logic [WORD_W-1:0] exp_rdata;
   logic              end_check;
   int                data_errors;
   int                proto_errors;
   int                rsp_seen;

   req_t              stim_q [$];
   logic [WORD_W-1:0] exp_q [$];
   int                n_req;
   int                next_idx;
   int                req_held;   // Request credits in hand
   int                rsp_held;   // Response credits granted and not yet spent
   int                stall;
   logic [31:0]       rng;
   int                cycles;
   int                limit;
   logic              timed_out;
   logic              file_error;

   function automatic logic [31:0] next_rand(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Each data line holds op, address, mask, write data and expected response data
   task automatic load_requests();
      int                fd;
      int                n;
      logic [8*160-1:0]  line;
      logic [31:0]       op;
      logic [31:0]       addr;
      logic [31:0]       mask;
      logic [31:0]       wdata;
      logic [31:0]       expd;
      req_t              r;
      fd = $fopen("testbench/cache_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open testbench/cache_input.txt");
         file_error = 1'b1;
      end else begin
         while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h", op, addr, mask, wdata, expd);
            if (n == 5) begin   // Comment lines do not parse
               r.write = op[0];
               r.addr  = addr[ADDR_W-1:0];
               r.mask  = mask[WORD_W/8-1:0];
               r.wdata = wdata;
               stim_q.push_back(r);
               exp_q.push_back(expd);
            end
         end
         $fclose(fd);
      end
   endtask

   always #4 clk = ~clk;

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      req_valid  = 1'b0;
      req        = '0;
      rsp_credit = 1'b0;
      exp_valid  = 1'b0;
      exp_write  = 1'b0;
      exp_rdata  = '0;
      end_check  = 1'b0;
      timed_out  = 1'b0;
      file_error = 1'b0;
      cycles     = 0;
      load_requests();
      n_req = stim_q.size();
      if (n_req == 0 && !file_error) begin
         $display("No requests found in testbench/cache_input.txt");
         file_error = 1'b1;
      end
      limit = 200 * n_req + 100;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      while (rsp_seen < n_req && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if (rsp_seen < n_req) begin
         timed_out = 1'b1;
         $display("Timeout after %0d cycles with %0d of %0d responses received",
                  cycles, rsp_seen, n_req);
      end
      end_check <= 1'b1;
      repeat (2) @(negedge clk);
      $display("Errors: data %0d, protocol %0d, timeout %0d, file %0d; responses %0d of %0d",
               data_errors, proto_errors, timed_out, file_error, rsp_seen, n_req);
      if (data_errors == 0 && proto_errors == 0 && !timed_out && !file_error) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Requests go out only while a credit is in hand
   always @(posedge clk) begin
      if (rst) begin
         req_valid <= 1'b0;
         exp_valid <= 1'b0;
         req_held  = REQ_CREDITS;
         next_idx  = 0;
      end else begin
         if (req_credit) begin
            req_held++;
         end
         if (next_idx < n_req && req_held > 0) begin
            req_valid <= 1'b1;
            req       <= stim_q[next_idx];
            exp_valid <= 1'b1;
            exp_write <= stim_q[next_idx].write;
            exp_rdata <= exp_q[next_idx];
            req_held--;
            next_idx++;
         end else begin
            req_valid <= 1'b0;
            exp_valid <= 1'b0;
         end
      end
   end

   // Response credits with random withheld stretches
   always @(posedge clk) begin
      if (rst) begin
         rsp_credit <= 1'b0;
         rsp_held   = 0;
         stall      = 0;
         rng        = SEED;
      end else begin
         if (rsp_valid) begin
            rsp_held--;
         end
         rng = next_rand(rng);
         if (stall > 0) begin
            stall--;
            rsp_credit <= 1'b0;
         end else if (rng[15:12] == 4'h0) begin
            stall = 8 + rng[4:0];
            rsp_credit <= 1'b0;
         end else if (rsp_held < RSP_DEPTH && rng[1:0] != 2'b00) begin
            rsp_credit <= 1'b1;
            rsp_held++;
         end else begin
            rsp_credit <= 1'b0;
         end
      end
   end

   l2_cache_top #(
      .REQ_CREDITS (REQ_CREDITS),
      .RSP_DEPTH   (RSP_DEPTH)
   ) DUT (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req        (req),
      .req_credit (req_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .rsp_credit (rsp_credit),
      .mem_req    (mem_req),
      .mem_cmd    (mem_cmd),
      .mem_ack    (mem_ack),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .mem_wdata  (mem_wdata),
      .mem_wrdy   (mem_wrdy)
   );

   burst_mem_model u_mem (
      .clk        (clk),
      .rst        (rst),
      .mem_req    (mem_req),
      .mem_cmd    (mem_cmd),
      .mem_ack    (mem_ack),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .mem_wdata  (mem_wdata),
      .mem_wrdy   (mem_wrdy)
   );

   l2_checker u_checker (
      .clk          (clk),
      .rst          (rst),
      .req_valid    (req_valid),
      .req_credit   (req_credit),
      .rsp_valid    (rsp_valid),
      .rsp          (rsp),
      .exp_valid    (exp_valid),
      .exp_write    (exp_write),
      .exp_rdata    (exp_rdata),
      .end_check    (end_check),
      .n_req        (n_req),
      .data_errors  (data_errors),
      .proto_errors (proto_errors),
      .rsp_seen     (rsp_seen)
   );

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

   typedef struct packed {
      logic                                write;
      cache_cfg_pkg::addr_u                addr;
      logic [cache_cfg_pkg::WORD_W/8-1:0]  mask;    // One bit per byte, 1 writes it
      logic [cache_cfg_pkg::WORD_W-1:0]    wdata;
   } req_t;

   typedef struct packed {
      logic                             write;
      logic [cache_cfg_pkg::WORD_W-1:0] rdata;
   } rsp_t;

   // Line address of a four-beat burst
   typedef struct packed {
      logic                                write;
      logic [cache_cfg_pkg::LINE_BITS-1:0] line;
   } mem_cmd_t;

endpackage

// File: verilog/cache_cfg_pkg.sv
package cache_cfg_pkg;

   localparam int WORD_W     = 32;
   localparam int ADDR_W     = 23;   // Word address, as on the DRAM command port
   localparam int WORD_BITS  = 2;
   localparam int INDEX_BITS = 6;
   localparam int TAG_BITS   = 15;
   localparam int LINE_WORDS = 4;
   localparam int LINE_BITS  = ADDR_W - WORD_BITS;

   typedef struct packed {
      logic [TAG_BITS-1:0]   tag;
      logic [INDEX_BITS-1:0] index;
      logic [WORD_BITS-1:0]  word;
   } cache_addr_t;

   // Burst commands carry only the line number
   typedef struct packed {
      logic [LINE_BITS-1:0] line;
      logic [WORD_BITS-1:0] word;
   } mem_addr_t;

   typedef union packed {
      cache_addr_t c;
      mem_addr_t   m;
   } addr_u;

endpackage

// File: verilog/l2_cache_top.sv
`timescale 1ns/1ps

module l2_cache_top #(
   parameter int REQ_CREDITS = 4,
   parameter int RSP_DEPTH   = 4
) (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             req_valid,
   input  bus_pkg::req_t                    req,
   output logic                             req_credit,
   output logic                             rsp_valid,
   output bus_pkg::rsp_t                    rsp,
   input  logic                             rsp_credit,
   output logic                             mem_req,
   output bus_pkg::mem_cmd_t                mem_cmd,
   input  logic                             mem_ack,
   input  logic [cache_cfg_pkg::WORD_W-1:0] mem_rdata,
   input  logic                             mem_rvalid,
   output logic [cache_cfg_pkg::WORD_W-1:0] mem_wdata,
   input  logic                             mem_wrdy
);
   import bus_pkg::*;

   logic dec_valid;
   logic dec_ready;
   req_t dec;
   logic push;
   rsp_t push_rsp;
   logic has_room;

   l2_req_decode #(
      .REQ_CREDITS (REQ_CREDITS)
   ) u_decode (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req        (req),
      .req_credit (req_credit),
      .dec_valid  (dec_valid),
      .dec        (dec),
      .dec_ready  (dec_ready)
   );

   l2_line_engine u_engine (
      .clk        (clk),
      .rst        (rst),
      .dec_valid  (dec_valid),
      .dec        (dec),
      .dec_ready  (dec_ready),
      .push       (push),
      .push_rsp   (push_rsp),
      .has_room   (has_room),
      .mem_req    (mem_req),
      .mem_cmd    (mem_cmd),
      .mem_ack    (mem_ack),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .mem_wdata  (mem_wdata),
      .mem_wrdy   (mem_wrdy)
   );

   l2_resp_queue #(
      .RSP_DEPTH (RSP_DEPTH)
   ) u_resp_queue (
      .clk        (clk),
      .rst        (rst),
      .push       (push),
      .push_rsp   (push_rsp),
      .has_room   (has_room),
      .rsp_credit (rsp_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp)
   );

endmodule

// File: verilog/l2_line_engine.sv
`timescale 1ns/1ps

module l2_line_engine (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             dec_valid,
   input  bus_pkg::req_t                    dec,
   output logic                             dec_ready,
   output logic                             push,
   output bus_pkg::rsp_t                    push_rsp,
   input  logic                             has_room,
   output logic                             mem_req,
   output bus_pkg::mem_cmd_t                mem_cmd,
   input  logic                             mem_ack,
   input  logic [cache_cfg_pkg::WORD_W-1:0] mem_rdata,
   input  logic                             mem_rvalid,
   output logic [cache_cfg_pkg::WORD_W-1:0] mem_wdata,
   input  logic                             mem_wrdy
);
   import cache_cfg_pkg::*;
   import bus_pkg::*;

   localparam int NUM_LINES = 2 ** INDEX_BITS;

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOOKUP,
      S_WB_REQ,
      S_WB_DATA,
      S_RF_REQ,
      S_RF_DATA
   } state_t;

   state_t                state;
   req_t                  cur;
   logic [WORD_BITS-1:0]  beat;
   logic [TAG_BITS-1:0]   tag_mem [NUM_LINES];
   logic [NUM_LINES-1:0]  valid;
   logic [NUM_LINES-1:0]  dirty;
   logic [WORD_W-1:0]     data_mem [NUM_LINES*LINE_WORDS];

   logic [INDEX_BITS-1:0] idx;
   logic                  hit;
   logic                  last_beat;
   logic [WORD_W-1:0]     cur_word;
   logic [WORD_W-1:0]     merged;
   addr_u                 victim;

   assign idx       = cur.addr.c.index;
   assign hit       = valid[idx] && (tag_mem[idx] == cur.addr.c.tag);
   assign cur_word  = data_mem[{idx, cur.addr.c.word}];
   assign last_beat = (beat == WORD_BITS'(LINE_WORDS - 1));

   always_comb begin
      merged = cur_word;
      for (int b = 0; b < WORD_W/8; b++) begin
         if (cur.mask[b]) begin
            merged[8*b +: 8] = cur.wdata[8*b +: 8];
         end
      end
   end

   // Victim address rebuilt from the stored tag
   always_comb begin
      victim.c.tag   = tag_mem[idx];
      victim.c.index = idx;
      victim.c.word  = '0;
   end

   assign dec_ready = (state == S_IDLE) && has_room;
   assign push      = (state == S_LOOKUP) && hit;
   assign mem_req   = (state == S_WB_REQ) || (state == S_RF_REQ);
   assign mem_wdata = data_mem[{idx, beat}];

   always_comb begin
      push_rsp.write = cur.write;
      push_rsp.rdata = cur.write ? merged : cur_word;
      mem_cmd.write  = (state == S_WB_REQ);
      mem_cmd.line   = (state == S_WB_REQ) ? victim.m.line : cur.addr.m.line;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
         beat  <= '0;
         valid <= '0;
         dirty <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (dec_valid && dec_ready) begin
                  state <= S_LOOKUP;
               end
            end
            S_LOOKUP: begin
               if (hit) begin
                  state <= S_IDLE;
                  if (cur.write) begin
                     dirty[idx] <= 1'b1;
                  end
               end else if (valid[idx] && dirty[idx]) begin
                  state <= S_WB_REQ;
               end else begin
                  state <= S_RF_REQ;
               end
            end
            S_WB_REQ: begin
               if (mem_ack) begin
                  state <= S_WB_DATA;
               end
            end
            S_WB_DATA: begin
               if (mem_wrdy) begin
                  beat <= beat + 1'b1;   // Wraps to 0 after the last word
                  if (last_beat) begin
                     state <= S_RF_REQ;
                  end
               end
            end
            S_RF_REQ: begin
               if (mem_ack) begin
                  state <= S_RF_DATA;
               end
            end
            S_RF_DATA: begin
               if (mem_rvalid) begin
                  beat <= beat + 1'b1;
                  if (last_beat) begin
                     valid[idx] <= 1'b1;
                     dirty[idx] <= 1'b0;
                     state      <= S_LOOKUP;   // Replay as a hit
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (dec_valid && dec_ready) begin
         cur <= dec;
      end
      if (push && cur.write) begin
         data_mem[{idx, cur.addr.c.word}] <= merged;
      end
      if (state == S_RF_DATA && mem_rvalid) begin
         data_mem[{idx, beat}] <= mem_rdata;
         if (last_beat) begin
            tag_mem[idx] <= cur.addr.c.tag;
         end
      end
   end

   a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
      mem_req && !mem_ack |=> mem_req && $stable(mem_cmd));

   // Response FIFO must have space for every push
   a_push_room: assert property (@(posedge clk) disable iff (rst)
      push |-> has_room);

endmodule

// File: verilog/l2_req_decode.sv
`timescale 1ns/1ps

module l2_req_decode #(
   parameter int REQ_CREDITS = 4
) (
   input  logic          clk,
   input  logic          rst,
   input  logic          req_valid,
   input  bus_pkg::req_t req,
   output logic          req_credit,
   output logic          dec_valid,
   output bus_pkg::req_t dec,
   input  logic          dec_ready
);
   import bus_pkg::*;

   localparam int PTR_W = (REQ_CREDITS > 1) ? $clog2(REQ_CREDITS) : 1;
   localparam int CNT_W = $clog2(REQ_CREDITS + 1);

   req_t             entries [REQ_CREDITS];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(REQ_CREDITS - 1)) ? '0 : p + 1'b1;
   endfunction

   assign dec_valid  = (count != '0);
   assign dec        = entries[rd_ptr];   // Head entry, read through the cache view downstream
   assign pop        = dec_valid && dec_ready;
   assign req_credit = pop;               // Credit goes back as the entry leaves

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (req_valid) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (req_valid && !pop) begin
            count <= count + 1'b1;
         end else if (!req_valid && pop) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid) begin
         entries[wr_ptr] <= req;
      end
   end

   // Requester must not spend more credits than it was given
   a_no_overspend: assert property (@(posedge clk) disable iff (rst)
      req_valid |-> (count < CNT_W'(REQ_CREDITS)));

endmodule

// File: verilog/l2_resp_queue.sv
`timescale 1ns/1ps

module l2_resp_queue #(
   parameter int RSP_DEPTH = 4
) (
   input  logic          clk,
   input  logic          rst,
   input  logic          push,
   input  bus_pkg::rsp_t push_rsp,
   output logic          has_room,
   input  logic          rsp_credit,
   output logic          rsp_valid,
   output bus_pkg::rsp_t rsp
);
   import bus_pkg::*;

   localparam int PTR_W = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
   localparam int CNT_W = $clog2(RSP_DEPTH + 1);

   rsp_t             entries [RSP_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] credits;   // Granted by the consumer, not yet used

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(RSP_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign has_room  = (count < CNT_W'(RSP_DEPTH));
   assign rsp_valid = (count != '0) && (credits != '0);
   assign rsp       = entries[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         credits <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (rsp_valid) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (push && !rsp_valid) begin
            count <= count + 1'b1;
         end else if (!push && rsp_valid) begin
            count <= count - 1'b1;
         end
         if (rsp_credit && !rsp_valid) begin
            credits <= credits + 1'b1;
         end else if (!rsp_credit && rsp_valid) begin
            credits <= credits - 1'b1;   // One credit per departure
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= push_rsp;
      end
   end

   // Consumer may not grant more than the FIFO can hold
   a_credit_limit: assert property (@(posedge clk) disable iff (rst)
      credits <= CNT_W'(RSP_DEPTH));

endmodule
